//--- logic/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    // RGB565 color fields, red in the upper bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // One pixel word, seen either whole or as color fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_u;

    typedef logic [10:0] coord_t; // Raster coordinate

    localparam int BORDER = 4; // Judgment border width in pixels

    // Overlay colors in RGB565
    localparam logic [15:0] COLOR_WHITE  = 16'hFFFF;
    localparam logic [15:0] COLOR_YELLOW = 16'hFFE0;
    localparam logic [15:0] COLOR_GREEN  = 16'h07E0;
    localparam logic [15:0] COLOR_RED    = 16'hF800;
    localparam logic [15:0] COLOR_BLUE   = 16'h001F;
    localparam logic [15:0] COLOR_BLACK  = 16'h0000;

endpackage

`default_nettype wire

//--- logic/blob_bounds.sv
`timescale 1ns/1ps
`default_nettype none

module blob_bounds import tracker_pkg::*; #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    input  wire         valid_i,
    input  wire         mask_i,
    input  wire coord_t hcount_i,
    input  wire coord_t vcount_i,
    output logic        found_o,
    output coord_t      center_x_o,
    output coord_t      center_y_o,
    output coord_t      min_x_o,
    output coord_t      max_x_o,
    output logic        frame_done_o
);

    logic        seen;    // Any masked pixel so far this frame
    logic        seen_nxt;
    logic        hit;
    logic        last_px;
    coord_t      min_x, max_x, min_y, max_y;
    coord_t      min_x_nxt, max_x_nxt, min_y_nxt, max_y_nxt;
    logic [11:0] sum_x, sum_y; // One extra bit so the halving keeps the carry

    assign hit      = valid_i && mask_i;
    assign last_px  = valid_i && (hcount_i == coord_t'(H_RES - 1))
                              && (vcount_i == coord_t'(V_RES - 1));
    assign seen_nxt = seen || hit;

    // Running box including the current pixel
    always_comb begin
        min_x_nxt = min_x;
        max_x_nxt = max_x;
        min_y_nxt = min_y;
        max_y_nxt = max_y;
        if (hit) begin
            if (!seen || hcount_i < min_x) begin
                min_x_nxt = hcount_i;
            end
            if (!seen || hcount_i > max_x) begin
                max_x_nxt = hcount_i;
            end
            if (!seen || vcount_i < min_y) begin
                min_y_nxt = vcount_i;
            end
            if (!seen || vcount_i > max_y) begin
                max_y_nxt = vcount_i;
            end
        end
    end

    assign sum_x = {1'b0, min_x_nxt} + {1'b0, max_x_nxt};
    assign sum_y = {1'b0, min_y_nxt} + {1'b0, max_y_nxt};

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            seen         <= 1'b0;
            found_o      <= 1'b0;
            frame_done_o <= 1'b0;
            center_x_o   <= '0;
            center_y_o   <= '0;
            min_x_o      <= '0;
            max_x_o      <= '0;
        end else begin
            frame_done_o <= last_px;
            if (last_px) begin
                seen    <= 1'b0; // Start over for the next frame
                found_o <= seen_nxt;
                if (seen_nxt) begin // Empty frame keeps the old center
                    center_x_o <= sum_x[11:1];
                    center_y_o <= sum_y[11:1];
                    min_x_o    <= min_x_nxt;
                    max_x_o    <= max_x_nxt;
                end
            end else begin
                seen <= seen_nxt;
            end
        end
    end

    // Box accumulators, only meaningful while seen is set
    always_ff @(posedge clk_pixel) begin
        min_x <= min_x_nxt;
        max_x <= max_x_nxt;
        min_y <= min_y_nxt;
        max_y <= max_y_nxt;
    end

endmodule

`default_nettype wire

//--- logic/ball_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ball_tracker import tracker_pkg::*; #(
    parameter int         H_RES      = 1280,
    parameter int         V_RES      = 720,
    parameter logic [7:0] BALL_LEVEL = 8'd200
) (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    input  wire         valid_i,
    input  wire pixel_u pixel_i,
    input  wire coord_t hcount_i,
    input  wire coord_t vcount_i,
    output logic        mask_o,
    output logic        found_o,
    output coord_t      center_x_o,
    output coord_t      center_y_o,
    output logic        frame_done_o
);

    logic [7:0]  red8, green8, blue8;
    logic [10:0] luma_sum; // 2R + 5G + B, at most 2040
    logic [7:0]  luma;

    // Widen the fields to 8 bits with zero fill
    assign red8   = {pixel_i.rgb.red, 3'b000};
    assign green8 = {pixel_i.rgb.green, 2'b00};
    assign blue8  = {pixel_i.rgb.blue, 3'b000};

    assign luma_sum = {2'b00, red8, 1'b0} + ({3'b000, green8} << 2) + {3'b000, green8}
                    + {3'b000, blue8};
    assign luma     = luma_sum[10:3]; // Divide by 8, drop remainder
    assign mask_o   = luma > BALL_LEVEL;

    blob_bounds #(
        .H_RES(H_RES),
        .V_RES(V_RES)
    ) u_bounds (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .valid_i     (valid_i),
        .mask_i      (mask_o),
        .hcount_i    (hcount_i),
        .vcount_i    (vcount_i),
        .found_o     (found_o),
        .center_x_o  (center_x_o),
        .center_y_o  (center_y_o),
        .min_x_o     (),
        .max_x_o     (),
        .frame_done_o(frame_done_o)
    );

endmodule

`default_nettype wire

//--- logic/hand_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module hand_tracker import tracker_pkg::*; #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    input  wire         valid_i,
    input  wire pixel_u pixel_i,
    input  wire coord_t hcount_i,
    input  wire coord_t vcount_i,
    input  wire [3:0]   hand_low_i,
    input  wire [3:0]   hand_high_i,
    output logic        mask_o,
    output logic        found_o,
    output coord_t      center_x_o,
    output coord_t      center_y_o,
    output coord_t      min_x_o,
    output coord_t      max_x_o
);

    logic [7:0] red8;
    logic [7:0] level_low;
    logic [7:0] level_high;

    assign red8       = {pixel_i.rgb.red, 3'b000};
    assign level_low  = {hand_low_i, 4'h0};  // Exclusive lower edge
    assign level_high = {hand_high_i, 4'hF}; // Inclusive upper edge

    assign mask_o = (red8 > level_low) && (red8 <= level_high);

    blob_bounds #(
        .H_RES(H_RES),
        .V_RES(V_RES)
    ) u_bounds (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .valid_i     (valid_i),
        .mask_i      (mask_o),
        .hcount_i    (hcount_i),
        .vcount_i    (vcount_i),
        .found_o     (found_o),
        .center_x_o  (center_x_o),
        .center_y_o  (center_y_o),
        .min_x_o     (min_x_o),
        .max_x_o     (max_x_o),
        .frame_done_o()
    );

endmodule

`default_nettype wire

//--- logic/overlay_mux.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mux import tracker_pkg::*; #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    input  wire         valid_i,
    input  wire pixel_u pixel_i,
    input  wire coord_t hcount_i,
    input  wire coord_t vcount_i,
    input  wire         view_sel_i,
    input  wire         ball_mask_i,
    input  wire         hand_mask_i,
    input  wire         ball_found_i,
    input  wire coord_t ball_x_i,
    input  wire coord_t ball_y_i,
    input  wire         hand_found_i,
    input  wire coord_t hand_x_i,
    input  wire coord_t hand_y_i,
    input  wire coord_t hand_min_x_i,
    input  wire coord_t hand_max_x_i,
    input  wire         frame_done_i,
    output pixel_u      pixel_o,
    output coord_t      hcount_o,
    output coord_t      vcount_o,
    output logic        valid_o,
    output logic        catch_ok_o
);

    logic   catch_calc, catch_q;
    logic   in_border, on_ball, on_hand;
    pixel_u pix_nxt;

    assign catch_calc = ball_found_i && hand_found_i
                     && (ball_x_i >= hand_min_x_i) && (ball_x_i <= hand_max_x_i);
    // New judgment already counts in the cycle frame_done is high
    assign catch_ok_o = frame_done_i ? catch_calc : catch_q;

    assign in_border = (hcount_i < coord_t'(BORDER)) || (hcount_i >= coord_t'(H_RES - BORDER))
                    || (vcount_i < coord_t'(BORDER)) || (vcount_i >= coord_t'(V_RES - BORDER));
    assign on_ball   = ball_found_i && ((hcount_i == ball_x_i) || (vcount_i == ball_y_i));
    assign on_hand   = hand_found_i && ((hcount_i == hand_x_i) || (vcount_i == hand_y_i));

    // First matching rule wins
    always_comb begin
        if (in_border) begin
            pix_nxt.raw = catch_ok_o ? COLOR_GREEN : COLOR_RED;
        end else if (on_ball) begin
            pix_nxt.raw = COLOR_WHITE;
        end else if (on_hand) begin
            pix_nxt.raw = COLOR_YELLOW;
        end else if (!view_sel_i) begin
            pix_nxt.raw = pixel_i.raw; // Camera view
        end else if (ball_mask_i) begin
            pix_nxt.raw = COLOR_WHITE;
        end else if (hand_mask_i) begin
            pix_nxt.raw = COLOR_BLUE;
        end else begin
            pix_nxt.raw = COLOR_BLACK;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            valid_o <= 1'b0;
            catch_q <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (frame_done_i) begin
                catch_q <= catch_calc;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        pixel_o  <= pix_nxt;
        hcount_o <= hcount_i;
        vcount_o <= vcount_i;
    end

endmodule

`default_nettype wire

//--- logic/juggle_vision_top.sv
`timescale 1ns/1ps
`default_nettype none

module juggle_vision_top import tracker_pkg::*; #(
    parameter int         H_RES      = 1280,
    parameter int         V_RES      = 720,
    parameter logic [7:0] BALL_LEVEL = 8'd200
) (
    input  wire         clk_pixel,
    input  wire         recent_reset,
    input  wire         valid_i,
    input  wire pixel_u pixel_i,
    input  wire coord_t hcount_i,
    input  wire coord_t vcount_i,
    input  wire         view_sel_i,
    input  wire [3:0]   hand_low_i,
    input  wire [3:0]   hand_high_i,
    output pixel_u      pixel_o,
    output coord_t      hcount_o,
    output coord_t      vcount_o,
    output logic        valid_o,
    output logic        results_valid_o,
    output logic        ball_found_o,
    output coord_t      ball_x_o,
    output coord_t      ball_y_o,
    output logic        hand_found_o,
    output logic        catch_ok_o
);

    // Stage 1 input registers
    logic       s1_valid;
    pixel_u     s1_pixel;
    coord_t     s1_hcount, s1_vcount;
    logic       s1_view_sel;
    logic [3:0] s1_hand_low, s1_hand_high;

    logic   ball_mask, hand_mask;
    coord_t hand_x, hand_y, hand_min_x, hand_max_x;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_i;
        end
    end

    // Switch settings travel with their pixel
    always_ff @(posedge clk_pixel) begin
        s1_pixel     <= pixel_i;
        s1_hcount    <= hcount_i;
        s1_vcount    <= vcount_i;
        s1_view_sel  <= view_sel_i;
        s1_hand_low  <= hand_low_i;
        s1_hand_high <= hand_high_i;
    end

    ball_tracker #(
        .H_RES     (H_RES),
        .V_RES     (V_RES),
        .BALL_LEVEL(BALL_LEVEL)
    ) u_ball (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .valid_i     (s1_valid),
        .pixel_i     (s1_pixel),
        .hcount_i    (s1_hcount),
        .vcount_i    (s1_vcount),
        .mask_o      (ball_mask),
        .found_o     (ball_found_o),
        .center_x_o  (ball_x_o),
        .center_y_o  (ball_y_o),
        .frame_done_o(results_valid_o)
    );

    hand_tracker #(
        .H_RES(H_RES),
        .V_RES(V_RES)
    ) u_hand (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .valid_i     (s1_valid),
        .pixel_i     (s1_pixel),
        .hcount_i    (s1_hcount),
        .vcount_i    (s1_vcount),
        .hand_low_i  (s1_hand_low),
        .hand_high_i (s1_hand_high),
        .mask_o      (hand_mask),
        .found_o     (hand_found_o),
        .center_x_o  (hand_x),
        .center_y_o  (hand_y),
        .min_x_o     (hand_min_x),
        .max_x_o     (hand_max_x)
    );

    // Output register inside the overlay is stage 2
    overlay_mux #(
        .H_RES(H_RES),
        .V_RES(V_RES)
    ) u_overlay (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .valid_i     (s1_valid),
        .pixel_i     (s1_pixel),
        .hcount_i    (s1_hcount),
        .vcount_i    (s1_vcount),
        .view_sel_i  (s1_view_sel),
        .ball_mask_i (ball_mask),
        .hand_mask_i (hand_mask),
        .ball_found_i(ball_found_o),
        .ball_x_i    (ball_x_o),
        .ball_y_i    (ball_y_o),
        .hand_found_i(hand_found_o),
        .hand_x_i    (hand_x),
        .hand_y_i    (hand_y),
        .hand_min_x_i(hand_min_x),
        .hand_max_x_i(hand_max_x),
        .frame_done_i(results_valid_o),
        .pixel_o     (pixel_o),
        .hcount_o    (hcount_o),
        .vcount_o    (vcount_o),
        .valid_o     (valid_o),
        .catch_ok_o  (catch_ok_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_juggle_vision.sv
`timescale 1ns/1ps
`default_nettype none

module tb_juggle_vision import tracker_pkg::*; ();

    localparam int         H_RES      = 32;
    localparam int         V_RES      = 16;
    localparam logic [7:0] BALL_LEVEL = 8'd200;
    localparam int         WAIT_LIMIT = 20;
    localparam logic [15:0] BALL_PIX  = 16'hFFFF; // Luma 250
    localparam logic [15:0] HAND_PIX  = 16'hA000; // Red 160 and luma 40

    // Expected DUT outputs for one input cycle
    typedef struct packed {
        logic        valid;
        logic [15:0] pix;
        coord_t      h;
        coord_t      v;
        logic        rv;
        logic        ball_found;
        coord_t      ball_x;
        coord_t      ball_y;
        logic        hand_found;
        logic        catch_ok;
    } expect_t;

    logic       clk_pixel = 1'b0;
    logic       recent_reset;
    logic       valid_i, view_sel_i;
    pixel_u     pixel_i;
    coord_t     hcount_i, vcount_i;
    logic [3:0] hand_low_i, hand_high_i;
    pixel_u     pixel_o;
    coord_t     hcount_o, vcount_o, ball_x_o, ball_y_o;
    logic       valid_o, results_valid_o, ball_found_o, hand_found_o, catch_ok_o;

    integer     seed;
    logic       checking;
    int         error_count, check_count, test_count, errors_at_start;
    logic       frame_view;
    logic [3:0] frame_lo, frame_hi;
    expect_t    cur_exp, exp_q1, exp_q2;

    // Scene objects with index 0 for the ball and 1 for the hand
    logic obj_on [2];
    int   obj_x0 [2], obj_x1 [2], obj_y0 [2], obj_y1 [2];

    // Reference model state
    logic acc_seen [2];
    int   acc_minx [2], acc_maxx [2], acc_miny [2], acc_maxy [2];
    logic res_found [2];
    int   res_cx [2], res_cy [2], res_minx [2], res_maxx [2];
    logic res_catch;

    logic [3:0] win_lo [4] = '{4'd9, 4'd10, 4'd2, 4'd0};
    logic [3:0] win_hi [4] = '{4'd10, 4'd12, 4'd9, 4'd15};
    logic [3:0] win_hit    = 4'b1001; // Bit k is the outcome for window k

    juggle_vision_top #(
        .H_RES     (H_RES),
        .V_RES     (V_RES),
        .BALL_LEVEL(BALL_LEVEL)
    ) u_dut (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .valid_i        (valid_i),
        .pixel_i        (pixel_i),
        .hcount_i       (hcount_i),
        .vcount_i       (vcount_i),
        .view_sel_i     (view_sel_i),
        .hand_low_i     (hand_low_i),
        .hand_high_i    (hand_high_i),
        .pixel_o        (pixel_o),
        .hcount_o       (hcount_o),
        .vcount_o       (vcount_o),
        .valid_o        (valid_o),
        .results_valid_o(results_valid_o),
        .ball_found_o   (ball_found_o),
        .ball_x_o       (ball_x_o),
        .ball_y_o       (ball_y_o),
        .hand_found_o   (hand_found_o),
        .catch_ok_o     (catch_ok_o)
    );

    always #50 clk_pixel = ~clk_pixel;

    function automatic int luma_of(logic [15:0] pix);
        int r8, g8, b8;
        r8 = int'(pix[15:11]) * 8;
        g8 = int'(pix[10:5]) * 4;
        b8 = int'(pix[4:0]) * 8;
        return (2 * r8 + 5 * g8 + b8) / 8;
    endfunction

    function automatic logic hand_hit(logic [15:0] pix, logic [3:0] lo, logic [3:0] hi);
        int r8;
        r8 = int'(pix[15:11]) * 8;
        return (r8 > int'(lo) * 16) && (r8 <= int'(hi) * 16 + 15);
    endfunction

    // Output pixel from the last completed frame's results
    function automatic logic [15:0] expected_pixel(logic [15:0] pix, int h, int v, logic view,
                                                   logic [3:0] lo, logic [3:0] hi);
        logic [15:0] px;
        if (h < BORDER || h >= H_RES - BORDER || v < BORDER || v >= V_RES - BORDER)
            px = res_catch ? COLOR_GREEN : COLOR_RED;
        else if (res_found[0] && (h == res_cx[0] || v == res_cy[0]))
            px = COLOR_WHITE;
        else if (res_found[1] && (h == res_cx[1] || v == res_cy[1]))
            px = COLOR_YELLOW;
        else if (!view)
            px = pix;
        else if (luma_of(pix) > int'(BALL_LEVEL))
            px = COLOR_WHITE;
        else if (hand_hit(pix, lo, hi))
            px = COLOR_BLUE;
        else
            px = COLOR_BLACK;
        return px;
    endfunction

    // Dark background fails both masks
    function automatic logic [15:0] scene_pixel(int h, int v);
        logic [15:0] px;
        px = {8'd0, 3'($random(seed)), 2'd0, 3'($random(seed))};
        if (obj_on[0] && h >= obj_x0[0] && h <= obj_x1[0] && v >= obj_y0[0] && v <= obj_y1[0])
            px = BALL_PIX;
        else if (obj_on[1] && h >= obj_x0[1] && h <= obj_x1[1]
                 && v >= obj_y0[1] && v <= obj_y1[1])
            px = HAND_PIX;
        return px;
    endfunction

    task automatic place_object(int idx, logic on, int x0, int x1, int y0, int y1);
        obj_on[idx] = on;
        obj_x0[idx] = x0;
        obj_x1[idx] = x1;
        obj_y0[idx] = y0;
        obj_y1[idx] = y1;
    endtask

    task automatic add_to_box(int idx, int h, int v);
        if (!acc_seen[idx] || h < acc_minx[idx])
            acc_minx[idx] = h;
        if (!acc_seen[idx] || h > acc_maxx[idx])
            acc_maxx[idx] = h;
        if (!acc_seen[idx] || v < acc_miny[idx])
            acc_miny[idx] = v;
        if (!acc_seen[idx] || v > acc_maxy[idx])
            acc_maxy[idx] = v;
        acc_seen[idx] = 1'b1;
    endtask

    task automatic close_frame();
        int i;
        for (i = 0; i < 2; i++) begin
            res_found[i] = acc_seen[i];
            if (acc_seen[i]) begin // Empty frame keeps the old box
                res_cx[i]   = (acc_minx[i] + acc_maxx[i]) / 2;
                res_cy[i]   = (acc_miny[i] + acc_maxy[i]) / 2;
                res_minx[i] = acc_minx[i];
                res_maxx[i] = acc_maxx[i];
            end
            acc_seen[i] = 1'b0;
        end
        res_catch = res_found[0] && res_found[1]
                 && res_cx[0] >= res_minx[1] && res_cx[0] <= res_maxx[1];
    endtask

    // One input cycle on the falling edge and its expected outputs
    task automatic drive_cycle(logic vld, int h, int v);
        logic [15:0] pix;
        @(negedge clk_pixel);
        pix         = scene_pixel(h, v);
        valid_i     = vld;
        pixel_i.raw = pix;
        hcount_i    = coord_t'(h);
        vcount_i    = coord_t'(v);
        view_sel_i  = frame_view;
        hand_low_i  = frame_lo;
        hand_high_i = frame_hi;
        cur_exp.valid = vld;
        cur_exp.pix   = expected_pixel(pix, h, v, frame_view, frame_lo, frame_hi);
        cur_exp.h     = coord_t'(h);
        cur_exp.v     = coord_t'(v);
        cur_exp.rv    = 1'b0;
        if (vld) begin
            if (luma_of(pix) > int'(BALL_LEVEL))
                add_to_box(0, h, v);
            if (hand_hit(pix, frame_lo, frame_hi))
                add_to_box(1, h, v);
            if (h == H_RES - 1 && v == V_RES - 1) begin
                close_frame();
                cur_exp.rv = 1'b1;
            end
        end
        cur_exp.ball_found = res_found[0];
        cur_exp.ball_x     = coord_t'(res_cx[0]);
        cur_exp.ball_y     = coord_t'(res_cy[0]);
        cur_exp.hand_found = res_found[1];
        cur_exp.catch_ok   = res_catch;
    endtask

    task automatic drive_frame(logic gaps);
        int h;
        int v;
        for (v = 0; v < V_RES; v++) begin
            for (h = 0; h < H_RES; h++) begin
                if (gaps && ($random(seed) & 3) == 0) begin
                    drive_cycle(1'b0, h, v);
                end
                drive_cycle(1'b1, h, v);
            end
        end
    endtask

    task automatic wait_results(output int cycles);
        cycles = 0;
        while (results_valid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            drive_cycle(1'b0, 0, 0);
            cycles++;
        end
        if (results_valid_o !== 1'b1) begin
            error_count++;
            $display("timeout: results_valid_o did not pulse within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic end_test(string name);
        test_count++;
        $display("test %0d %s done, %0d mismatches", test_count, name,
                 error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    always @(posedge clk_pixel) begin
        exp_q1 <= cur_exp;
        exp_q2 <= exp_q1;
    end

    // Outputs are checked two cycles after their input
    always @(negedge clk_pixel) begin
        if (checking) begin
            check_value("valid_o", 32'(valid_o), 32'(exp_q2.valid));
            check_value("results_valid_o", 32'(results_valid_o), 32'(exp_q2.rv));
            check_value("ball_found_o", 32'(ball_found_o), 32'(exp_q2.ball_found));
            check_value("ball_x_o", 32'(ball_x_o), 32'(exp_q2.ball_x));
            check_value("ball_y_o", 32'(ball_y_o), 32'(exp_q2.ball_y));
            check_value("hand_found_o", 32'(hand_found_o), 32'(exp_q2.hand_found));
            check_value("catch_ok_o", 32'(catch_ok_o), 32'(exp_q2.catch_ok));
            if (exp_q2.valid) begin
                check_value("pixel_o", 32'(pixel_o.raw), 32'(exp_q2.pix));
                check_value("hcount_o", 32'(hcount_o), 32'(exp_q2.h));
                check_value("vcount_o", 32'(vcount_o), 32'(exp_q2.v));
            end
        end
    end

    initial begin
        int k;
        int lat;
        seed = 32'h6b9dfe4c;
        recent_reset = 1'b1;
        valid_i = 1'b0;
        pixel_i.raw = 16'h0000;
        hcount_i = '0;
        vcount_i = '0;
        view_sel_i = 1'b0;
        hand_low_i = 4'd0;
        hand_high_i = 4'd0;
        frame_view = 1'b0;
        frame_lo = 4'd0;
        frame_hi = 4'd14;
        checking = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        errors_at_start = 0;
        cur_exp = '0;
        res_catch = 1'b0;
        for (k = 0; k < 2; k++) begin
            place_object(k, 1'b0, 0, 0, 0, 0);
            acc_seen[k] = 1'b0;
            res_found[k] = 1'b0;
            res_cx[k] = 0;
            res_cy[k] = 0;
            res_minx[k] = 0;
            res_maxx[k] = 0;
        end

        repeat (10) @(posedge clk_pixel);
        drive_cycle(1'b0, 0, 0);
        recent_reset = 1'b0;
        @(posedge clk_pixel);
        checking = 1'b1;

        // Idle after reset and then a frame with nothing in it
        repeat (5) drive_cycle(1'b0, 0, 0);
        check_value("valid_o idle", 32'(valid_o), 32'd0);
        check_value("results_valid_o idle", 32'(results_valid_o), 32'd0);
        drive_frame(1'b0);
        wait_results(lat);
        check_value("ball_found_o empty", 32'(ball_found_o), 32'd0);
        check_value("hand_found_o empty", 32'(hand_found_o), 32'd0);
        check_value("catch_ok_o empty", 32'(catch_ok_o), 32'd0);
        end_test("empty frame");

        place_object(0, 1'b1, 5, 12, 6, 9);
        drive_frame(1'b0);
        wait_results(lat);
        check_value("results latency", 32'(lat), 32'd2);
        check_value("ball_found_o", 32'(ball_found_o), 32'd1);
        check_value("ball_x_o center", 32'(ball_x_o), 32'd8);
        check_value("ball_y_o center", 32'(ball_y_o), 32'd7);
        end_test("bright ball");

        place_object(0, 1'b0, 0, 0, 0, 0);
        place_object(1, 1'b1, 20, 27, 5, 10);
        for (k = 0; k < 4; k++) begin
            frame_lo = win_lo[k];
            frame_hi = win_hi[k];
            drive_frame(1'b0);
            wait_results(lat);
            check_value("hand_found_o window", 32'(hand_found_o), 32'(win_hit[k]));
        end
        end_test("hand window");

        // Ball inside the hand span and then outside it
        frame_lo = 4'd9;
        frame_hi = 4'd10;
        place_object(0, 1'b1, 10, 13, 5, 7);
        place_object(1, 1'b1, 8, 16, 9, 12);
        drive_frame(1'b0);
        wait_results(lat);
        check_value("catch_ok_o inside", 32'(catch_ok_o), 32'd1);
        place_object(0, 1'b1, 22, 25, 5, 7);
        drive_frame(1'b0); // Green border from the catch
        wait_results(lat);
        check_value("catch_ok_o outside", 32'(catch_ok_o), 32'd0);
        end_test("catch judgment");

        drive_frame(1'b0); // Red border and crosshairs at 23,6 and 12,10
        wait_results(lat);
        check_value("ball_x_o steady", 32'(ball_x_o), 32'd23);
        end_test("crosshairs");

        place_object(0, 1'b1, 14, 17, 6, 8);
        place_object(1, 1'b1, 10, 20, 7, 12);
        for (k = 0; k < 2; k++) begin
            frame_view = (k == 0);
            drive_frame(1'b1);
            wait_results(lat);
            check_value("ball_x_o gaps", 32'(ball_x_o), 32'd15);
            check_value("ball_y_o gaps", 32'(ball_y_o), 32'd7);
            check_value("catch_ok_o gaps", 32'(catch_ok_o), 32'd1);
        end
        drive_frame(1'b0);
        wait_results(lat);
        end_test("view select and gaps");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/tracker_pkg.sv
logic/blob_bounds.sv
logic/ball_tracker.sv
logic/hand_tracker.sv
logic/overlay_mux.sv
logic/juggle_vision_top.sv
testbench/tb_juggle_vision.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search its output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_juggle_vision -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "^TB PASSED$" > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
